//--- page_cache.f
hdl/page_cache_pkg.sv
hdl/page_store.sv
hdl/page_cache_ctrl.sv
hdl/page_refill.sv
hdl/page_writeback.sv
hdl/page_cache_top.sv
tb/axi_mem_model.sv
tb/page_cache_props.sv
tb/tb_page_cache.sv

//--- run.sh
#!/bin/sh
# build and run the page cache testbench, exit status is the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_page_cache \
    -f page_cache.f

./obj_dir/Vtb_page_cache

//--- tb/tb_page_cache.sv
module tb_page_cache import page_cache_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 8;
    // full writeback plus full refill, a few cycles per beat under back-pressure
    localparam int CYCLES_PER_ENTRY = 2 * 1024 * 8;

    typedef enum logic [2:0] {OP_RD, OP_WR, OP_WRRD, OP_DUMP, OP_STALL} op_t;

    typedef struct packed {
        op_t   op;
        logic  miss;
        addr_t addr;
        word_t data;
        word_t expv;
    } entry_t;

    logic       CLK;
    logic       RST;
    logic       stall;
    cpu_req_t   req;
    logic       hit;
    logic       rvalid;
    word_t      rdata;
    addr_t      roaddr;
    addr_t      m_axi_awaddr;
    axi_len_t   m_axi_awlen;
    axi_size_t  m_axi_awsize;
    axi_burst_t m_axi_awburst;
    logic       m_axi_awvalid;
    logic       m_axi_awready;
    word_t      m_axi_wdata;
    logic [3:0] m_axi_wstrb;
    logic       m_axi_wlast;
    logic       m_axi_wvalid;
    logic       m_axi_wready;
    logic       m_axi_bvalid;
    logic       m_axi_bready;
    addr_t      m_axi_araddr;
    axi_len_t   m_axi_arlen;
    axi_size_t  m_axi_arsize;
    axi_burst_t m_axi_arburst;
    logic       m_axi_arvalid;
    logic       m_axi_arready;
    word_t      m_axi_rdata;
    logic       m_axi_rlast;
    logic       m_axi_rvalid;
    logic       m_axi_rready;
    addr_t      dump_addr;
    word_t      dump_data;

    // cached page written since its refill
    logic       page_dirty;

    entry_t     tests [$];

    page_cache_top #(.BURST_BEATS(AXI_BURST_BEATS)) UUT (.*);

    axi_mem_model mem_model (.*);

    bind page_cache_top page_cache_props #(.BURST_BEATS(BURST_BEATS)) u_props (
        .CLK      (CLK),
        .RST      (RST),
        .awaddr   (m_axi_awaddr),
        .awlen    (m_axi_awlen),
        .awsize   (m_axi_awsize),
        .awburst  (m_axi_awburst),
        .awvalid  (m_axi_awvalid),
        .awready  (m_axi_awready),
        .wdata    (m_axi_wdata),
        .wstrb    (m_axi_wstrb),
        .wlast    (m_axi_wlast),
        .wvalid   (m_axi_wvalid),
        .wready   (m_axi_wready),
        .araddr   (m_axi_araddr),
        .arlen    (m_axi_arlen),
        .arsize   (m_axi_arsize),
        .arburst  (m_axi_arburst),
        .arvalid  (m_axi_arvalid),
        .arready  (m_axi_arready),
        .wb_req   (wb_req),
        .wb_ack   (wb_ack),
        .fill_req (fill_req),
        .fill_ack (fill_ack)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    task automatic abort_run(string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t expv);
        if (got !== expv) begin
            abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, expv));
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t expv);
        if (got !== expv) begin
            abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, expv));
        end
    endtask

    task automatic check_flag(string name, logic got, logic expv);
        if (got !== expv) begin
            abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, expv));
        end
    endtask

    // what the memory holds where nothing was written
    function automatic word_t mem_pattern(addr_t a);
        return a ^ 32'h5a5a0000;
    endfunction

    function automatic void add_entry(op_t op, logic miss, addr_t a, word_t d, word_t expv);
        entry_t e;
        e.op   = op;
        e.miss = miss;
        e.addr = a;
        e.data = d;
        e.expv = expv;
        tests.push_back(e);
    endfunction

    function automatic void build_table();
        addr_t p0;
        addr_t p1;
        addr_t p2;
        p0 = 32'h0001_0000;
        p1 = 32'h0002_3000;
        p2 = 32'h0004_5000;
        add_entry(OP_RD,   1'b1, p0,           '0, mem_pattern(p0));
        add_entry(OP_RD,   1'b0, p0 + 32'h004, '0, mem_pattern(p0 + 32'h004));
        add_entry(OP_RD,   1'b0, p0 + 32'hffc, '0, mem_pattern(p0 + 32'hffc));
        add_entry(OP_WR,   1'b0, p0 + 32'h010, 32'hdeadbeef, 32'hdeadbeef);
        add_entry(OP_RD,   1'b0, p0 + 32'h010, '0, 32'hdeadbeef);
        add_entry(OP_STALL, 1'b0, p0 + 32'h010, '0, 32'hdeadbeef);
        add_entry(OP_WRRD, 1'b0, p0 + 32'h020, 32'h12345678, 32'h12345678);
        add_entry(OP_WR,   1'b0, p0 + 32'h800, 32'hcafef00d, 32'hcafef00d);
        add_entry(OP_WR,   1'b0, p0 + 32'hffc, 32'h0badf00d, 32'h0badf00d);
        // dirty page goes out before the new one comes in
        add_entry(OP_RD,   1'b1, p1 + 32'h040, '0, mem_pattern(p1 + 32'h040));
        add_entry(OP_DUMP, 1'b0, p0 + 32'h010, '0, 32'hdeadbeef);
        add_entry(OP_DUMP, 1'b0, p0 + 32'h020, '0, 32'h12345678);
        add_entry(OP_DUMP, 1'b0, p0 + 32'h800, '0, 32'hcafef00d);
        add_entry(OP_DUMP, 1'b0, p0 + 32'hffc, '0, 32'h0badf00d);
        add_entry(OP_DUMP, 1'b0, p0 + 32'h014, '0, mem_pattern(p0 + 32'h014));
        add_entry(OP_DUMP, 1'b0, p0,           '0, mem_pattern(p0));
        add_entry(OP_RD,   1'b0, p1 + 32'h100, '0, mem_pattern(p1 + 32'h100));
        // clean page, refill only
        add_entry(OP_RD,   1'b1, p2,           '0, mem_pattern(p2));
        add_entry(OP_RD,   1'b1, p0 + 32'h010, '0, 32'hdeadbeef);
        add_entry(OP_RD,   1'b0, p0 + 32'h024, '0, mem_pattern(p0 + 32'h024));
        add_entry(OP_RD,   1'b0, p0 + 32'hffc, '0, 32'h0badf00d);
        add_entry(OP_WR,   1'b0, p0 + 32'h400, 32'h600dcafe, 32'h600dcafe);
        add_entry(OP_RD,   1'b1, p2 + 32'h008, '0, mem_pattern(p2 + 32'h008));
        add_entry(OP_DUMP, 1'b0, p0 + 32'h400, '0, 32'h600dcafe);
        add_entry(OP_DUMP, 1'b0, p0 + 32'h010, '0, 32'hdeadbeef);
    endfunction

    task automatic read_page_word(entry_t e);
        @(negedge CLK);
        req       = '0;
        req.rden  = 1'b1;
        req.raddr = e.addr;
        @(negedge CLK);
        check_flag("hit", hit, !e.miss);
        if (e.miss) begin
            while (!hit) begin
                check_flag("rvalid", rvalid, 1'b0);
                if (!page_dirty) begin
                    // clean page, no write channel traffic
                    check_flag("m_axi_awvalid", m_axi_awvalid, 1'b0);
                end
                @(negedge CLK);
            end
            // tag swapped on the last edge, word registers on the next
            @(negedge CLK);
            page_dirty = 1'b0;
        end
        check_flag("rvalid", rvalid, 1'b1);
        check_word("rdata", rdata, e.expv);
        check_addr("roaddr", roaddr, e.addr);
        req.rden = 1'b0;
    endtask

    task automatic write_page_word(entry_t e);
        @(negedge CLK);
        req       = '0;
        req.wren  = 1'b1;
        req.waddr = e.addr;
        req.wdata = e.data;
        page_dirty = 1'b1;
        @(negedge CLK);
        check_flag("rvalid", rvalid, 1'b0);
        req.wren = 1'b0;
    endtask

    // same index written and read in one cycle
    task automatic write_and_read(entry_t e);
        @(negedge CLK);
        req       = '0;
        req.rden  = 1'b1;
        req.raddr = e.addr;
        req.wren  = 1'b1;
        req.waddr = e.addr;
        req.wdata = e.data;
        page_dirty = 1'b1;
        @(negedge CLK);
        check_flag("hit", hit, 1'b1);
        check_flag("rvalid", rvalid, 1'b1);
        check_word("rdata", rdata, e.expv);
        check_addr("roaddr", roaddr, e.addr);
        req = '0;
    endtask

    // read outputs hold under stall while the request moves on
    task automatic read_with_stall(entry_t e);
        @(negedge CLK);
        req       = '0;
        req.rden  = 1'b1;
        req.raddr = e.addr;
        @(negedge CLK);
        stall     = 1'b1;
        req.rden  = 1'b0;
        req.raddr = e.addr ^ 32'h0000_0040;
        repeat (2) @(negedge CLK);
        check_flag("rvalid", rvalid, 1'b1);
        check_word("rdata", rdata, e.expv);
        check_addr("roaddr", roaddr, e.addr);
        stall = 1'b0;
    endtask

    task automatic compare_memory(entry_t e);
        @(negedge CLK);
        dump_addr = e.addr;
        @(negedge CLK);
        check_word($sformatf("mem[%h]", e.addr), dump_data, e.expv);
    endtask

    initial begin
        int limit;
        @(negedge RST);
        limit = tests.size() * CYCLES_PER_ENTRY;
        repeat (limit) @(posedge CLK);
        abort_run($sformatf("timeout, test table not finished after %0d cycles", limit));
    end

    initial begin
        RST        = 1'b1;
        stall      = 1'b0;
        req        = '0;
        dump_addr  = '0;
        page_dirty = 1'b0;
        build_table();
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
        @(negedge CLK);
        check_flag("hit", hit, 1'b1);
        check_flag("rvalid", rvalid, 1'b0);
        check_flag("m_axi_arvalid", m_axi_arvalid, 1'b0);
        check_flag("m_axi_awvalid", m_axi_awvalid, 1'b0);
        check_flag("m_axi_wvalid", m_axi_wvalid, 1'b0);
        foreach (tests[i]) begin
            case (tests[i].op)
                OP_RD:    read_page_word(tests[i]);
                OP_WR:    write_page_word(tests[i]);
                OP_WRRD:  write_and_read(tests[i]);
                OP_STALL: read_with_stall(tests[i]);
                default:  compare_memory(tests[i]);
            endcase
        end
        $display("Verification passed");
        $finish;
    end

endmodule

//--- tb/page_cache_props.sv
module page_cache_props import page_cache_pkg::*; #(
    parameter int BURST_BEATS = AXI_BURST_BEATS
) (
    input logic       CLK,
    input logic       RST,
    input addr_t      awaddr,
    input axi_len_t   awlen,
    input axi_size_t  awsize,
    input axi_burst_t awburst,
    input logic       awvalid,
    input logic       awready,
    input word_t      wdata,
    input logic [3:0] wstrb,
    input logic       wlast,
    input logic       wvalid,
    input logic       wready,
    input addr_t      araddr,
    input axi_len_t   arlen,
    input axi_size_t  arsize,
    input axi_burst_t arburst,
    input logic       arvalid,
    input logic       arready,
    input logic       wb_req,
    input logic       wb_ack,
    input logic       fill_req,
    input logic       fill_ack
);
    timeunit 1ns;
    timeprecision 100ps;

    // W beats accepted so far in the current burst
    logic [8:0] wbeat;

    always_ff @(posedge CLK) begin
        if (RST) begin
            wbeat <= '0;
        end else if (wvalid && wready) begin
            wbeat <= wlast ? 9'd0 : wbeat + 9'd1;
        end
    end

    ar_hold: assert property (@(posedge CLK) disable iff (RST)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("AR valid or address changed before ready");

    aw_hold: assert property (@(posedge CLK) disable iff (RST)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("AW valid or address changed before ready");

    w_hold: assert property (@(posedge CLK) disable iff (RST)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else $error("W valid, data or last changed before ready");

    // word-sized INCR bursts of fixed length
    ar_format: assert property (@(posedge CLK) disable iff (RST)
        arvalid |-> arlen == BURST_BEATS - 1 && arsize == 3'b010 && arburst == 2'b01)
        else $error("AR burst length, size or type wrong");

    aw_format: assert property (@(posedge CLK) disable iff (RST)
        awvalid |-> awlen == BURST_BEATS - 1 && awsize == 3'b010 && awburst == 2'b01)
        else $error("AW burst length, size or type wrong");

    w_strobe_last: assert property (@(posedge CLK) disable iff (RST)
        wvalid |-> wstrb == 4'hf && (wlast == (wbeat == BURST_BEATS - 1)))
        else $error("W strobe not full or last flag on the wrong beat");

    // a clean page never reaches the write channel
    aw_only_on_writeback: assert property (@(posedge CLK) disable iff (RST)
        awvalid |-> wb_req)
        else $error("AW issued without a writeback request");

    wb_req_held: assert property (@(posedge CLK) disable iff (RST)
        wb_req && !wb_ack |=> wb_req)
        else $error("writeback request dropped before ack");

    wb_ack_held: assert property (@(posedge CLK) disable iff (RST)
        wb_req && wb_ack |=> wb_ack)
        else $error("writeback ack dropped before request fell");

    fill_req_held: assert property (@(posedge CLK) disable iff (RST)
        fill_req && !fill_ack |=> fill_req)
        else $error("refill request dropped before ack");

    fill_ack_held: assert property (@(posedge CLK) disable iff (RST)
        fill_req && fill_ack |=> fill_ack)
        else $error("refill ack dropped before request fell");

    one_engine: assert property (@(posedge CLK) disable iff (RST)
        !(wb_req && fill_req))
        else $error("writeback and refill requested together");

endmodule

//--- tb/axi_mem_model.sv
module axi_mem_model import page_cache_pkg::*; (
    input  logic     CLK,
    input  logic     RST,
    input  addr_t    m_axi_awaddr,
    input  logic     m_axi_awvalid,
    output logic     m_axi_awready,
    input  word_t    m_axi_wdata,
    input  logic     m_axi_wlast,
    input  logic     m_axi_wvalid,
    output logic     m_axi_wready,
    output logic     m_axi_bvalid,
    input  logic     m_axi_bready,
    input  addr_t    m_axi_araddr,
    input  axi_len_t m_axi_arlen,
    input  logic     m_axi_arvalid,
    output logic     m_axi_arready,
    output word_t    m_axi_rdata,
    output logic     m_axi_rlast,
    output logic     m_axi_rvalid,
    input  logic     m_axi_rready,
    input  addr_t    dump_addr,
    output word_t    dump_data
);
    timeunit 1ns;
    timeprecision 100ps;

    word_t      mem [addr_t];
    integer     seed = 32'h1450ec65;

    logic       aw_rdy = 1'b0;
    logic       w_rdy = 1'b0;
    logic       b_vld = 1'b0;
    logic       ar_rdy = 1'b0;
    logic       r_vld = 1'b0;
    logic       r_last = 1'b0;
    word_t      r_word = '0;

    addr_t      wa;
    addr_t      ra;
    logic [8:0] rcnt;
    logic       w_open;
    logic       b_due;
    logic       r_open;
    logic       r_taken;

    assign m_axi_awready = aw_rdy;
    assign m_axi_wready  = w_rdy;
    assign m_axi_bvalid  = b_vld;
    assign m_axi_arready = ar_rdy;
    assign m_axi_rvalid  = r_vld;
    assign m_axi_rlast   = r_last;
    assign m_axi_rdata   = r_word;

    // unwritten words read back as a pattern of their own address
    function automatic word_t peek(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    function automatic logic chance();
        return ($random(seed) & 32'sd3) != 0;
    endfunction

    // handshakes and storage, one burst per channel at a time
    always @(posedge CLK) begin
        if (RST) begin
            wa      <= '0;
            ra      <= '0;
            rcnt    <= '0;
            w_open  <= 1'b0;
            b_due   <= 1'b0;
            r_open  <= 1'b0;
            r_taken <= 1'b0;
        end else begin
            if (m_axi_awvalid && aw_rdy) begin
                wa     <= m_axi_awaddr;
                w_open <= 1'b1;
            end
            if (m_axi_wvalid && w_rdy) begin
                mem[wa] = m_axi_wdata;
                wa <= wa + 32'd4;
                if (m_axi_wlast) begin
                    w_open <= 1'b0;
                    b_due  <= 1'b1;
                end
            end
            if (b_vld && m_axi_bready) begin
                b_due <= 1'b0;
            end
            if (m_axi_arvalid && ar_rdy) begin
                ra     <= m_axi_araddr;
                rcnt   <= {1'b0, m_axi_arlen} + 9'd1;
                r_open <= 1'b1;
            end
            r_taken <= r_vld && m_axi_rready;
            if (r_vld && m_axi_rready) begin
                ra   <= ra + 32'd4;
                rcnt <= rcnt - 9'd1;
                if (rcnt == 9'd1) begin
                    r_open <= 1'b0;
                end
            end
        end
        dump_data <= peek(dump_addr);
    end

    // ready and valid changes away from the sampling edge
    always @(negedge CLK) begin
        if (RST) begin
            aw_rdy <= 1'b0;
            w_rdy  <= 1'b0;
            b_vld  <= 1'b0;
            ar_rdy <= 1'b0;
            r_vld  <= 1'b0;
            r_last <= 1'b0;
        end else begin
            aw_rdy <= !w_open && !b_due && chance();
            w_rdy  <= w_open && chance();
            b_vld  <= b_due && (b_vld || chance());
            ar_rdy <= !r_open && chance();
            if (!r_open) begin
                r_vld <= 1'b0;
            end else if (!r_vld || r_taken) begin
                r_vld <= chance();
            end
            r_word <= peek(ra);
            r_last <= (rcnt == 9'd1);
        end
    end

endmodule

//--- hdl/page_cache_top.sv
module page_cache_top import page_cache_pkg::*; #(
    parameter int BURST_BEATS = AXI_BURST_BEATS
) (
    input  logic       CLK,
    input  logic       RST,
    input  logic       stall,
    input  cpu_req_t   req,
    output logic       hit,
    output logic       rvalid,
    output word_t      rdata,
    output addr_t      roaddr,
    // write address
    output addr_t      m_axi_awaddr,
    output axi_len_t   m_axi_awlen,
    output axi_size_t  m_axi_awsize,
    output axi_burst_t m_axi_awburst,
    output logic       m_axi_awvalid,
    input  logic       m_axi_awready,
    // write data and response
    output word_t      m_axi_wdata,
    output logic [3:0] m_axi_wstrb,
    output logic       m_axi_wlast,
    output logic       m_axi_wvalid,
    input  logic       m_axi_wready,
    input  logic       m_axi_bvalid,
    output logic       m_axi_bready,
    // read address and data
    output addr_t      m_axi_araddr,
    output axi_len_t   m_axi_arlen,
    output axi_size_t  m_axi_arsize,
    output axi_burst_t m_axi_arburst,
    output logic       m_axi_arvalid,
    input  logic       m_axi_arready,
    input  word_t      m_axi_rdata,
    input  logic       m_axi_rlast,
    input  logic       m_axi_rvalid,
    output logic       m_axi_rready
);

    logic      wb_req, wb_ack, fill_req, fill_ack;
    page_tag_t wb_tag, fill_tag;
    logic      bwr_en;
    word_idx_t bwr_idx, brd_idx;
    word_t     bwr_data, brd_data;

    page_cache_ctrl u_ctrl (
        .CLK, .RST, .stall, .req, .hit, .rvalid, .roaddr,
        .wb_req, .wb_tag, .wb_ack, .fill_req, .fill_tag, .fill_ack
    );

    page_store u_store (
        .CLK, .RST, .stall, .req, .rdata,
        .bwr_en, .bwr_idx, .bwr_data, .brd_idx, .brd_data
    );

    page_refill #(.BURST_BEATS(BURST_BEATS)) u_refill (
        .CLK, .RST, .fill_req, .fill_tag, .fill_ack,
        .m_axi_araddr, .m_axi_arlen, .m_axi_arsize, .m_axi_arburst,
        .m_axi_arvalid, .m_axi_arready,
        .m_axi_rdata, .m_axi_rlast, .m_axi_rvalid, .m_axi_rready,
        .bwr_en, .bwr_idx, .bwr_data
    );

    page_writeback #(.BURST_BEATS(BURST_BEATS)) u_writeback (
        .CLK, .RST, .wb_req, .wb_tag, .wb_ack,
        .m_axi_awaddr, .m_axi_awlen, .m_axi_awsize, .m_axi_awburst,
        .m_axi_awvalid, .m_axi_awready,
        .m_axi_wdata, .m_axi_wstrb, .m_axi_wlast, .m_axi_wvalid, .m_axi_wready,
        .m_axi_bvalid, .m_axi_bready,
        .brd_idx, .brd_data
    );

endmodule

//--- hdl/page_writeback.sv
module page_writeback import page_cache_pkg::*; #(
    parameter int BURST_BEATS = AXI_BURST_BEATS
) (
    input  logic       CLK,
    input  logic       RST,
    input  logic       wb_req,
    input  page_tag_t  wb_tag,
    output logic       wb_ack,
    output addr_t      m_axi_awaddr,
    output axi_len_t   m_axi_awlen,
    output axi_size_t  m_axi_awsize,
    output axi_burst_t m_axi_awburst,
    output logic       m_axi_awvalid,
    input  logic       m_axi_awready,
    output word_t      m_axi_wdata,
    output logic [3:0] m_axi_wstrb,
    output logic       m_axi_wlast,
    output logic       m_axi_wvalid,
    input  logic       m_axi_wready,
    input  logic       m_axi_bvalid,
    output logic       m_axi_bready,
    output word_idx_t  brd_idx,
    input  word_t      brd_data
);

    localparam addr_t BURST_BYTES = addr_t'(BURST_BEATS * 4);
    localparam int    BEAT_W      = $clog2(BURST_BEATS);

    wb_state_t state;
    word_idx_t rd_idx;
    word_idx_t rd_idx_nxt;
    logic      load;
    logic      start;

    assign m_axi_awlen   = axi_len_t'(BURST_BEATS - 1);
    assign m_axi_awsize  = AXI_SIZE_WORD;
    assign m_axi_awburst = AXI_BURST_INCR;
    assign m_axi_wstrb   = '1;
    assign m_axi_bready  = (state == WB_RESP);

    assign start = (state == WB_IDLE) && wb_req && !wb_ack;
    // next W word goes into the register when the slot is free
    assign load  = (state == WB_DATA) && (!m_axi_wvalid || (m_axi_wready && !m_axi_wlast));

    // index is presented early so brd_data always holds mem[rd_idx]
    always_comb begin
        rd_idx_nxt = rd_idx;
        if (state == WB_IDLE) begin
            rd_idx_nxt = '0;
        end else if (load) begin
            rd_idx_nxt = rd_idx + 1'b1;
        end
    end

    assign brd_idx = rd_idx_nxt;

    always_ff @(posedge CLK) begin
        if (RST) begin
            state         <= WB_IDLE;
            rd_idx        <= '0;
            m_axi_awvalid <= 1'b0;
            m_axi_wvalid  <= 1'b0;
            m_axi_wlast   <= 1'b0;
            wb_ack        <= 1'b0;
        end else begin
            rd_idx <= rd_idx_nxt;
            case (state)
                WB_IDLE: begin
                    if (start) begin
                        m_axi_awvalid <= 1'b1;
                        state         <= WB_ADDR;
                    end else if (!wb_req) begin
                        wb_ack <= 1'b0;
                    end
                end
                WB_ADDR: begin
                    if (m_axi_awready) begin
                        m_axi_awvalid <= 1'b0;
                        state         <= WB_DATA;
                    end
                end
                WB_DATA: begin
                    if (load) begin
                        m_axi_wvalid <= 1'b1;
                        m_axi_wlast  <= (rd_idx[BEAT_W-1:0] == {BEAT_W{1'b1}});
                    end else if (m_axi_wvalid && m_axi_wready && m_axi_wlast) begin
                        m_axi_wvalid <= 1'b0;
                        m_axi_wlast  <= 1'b0;
                        state        <= WB_RESP;
                    end
                end
                WB_RESP: begin
                    if (m_axi_bvalid) begin
                        if (m_axi_awaddr[PAGE_OFS_W-1:0] == '0) begin
                            wb_ack <= 1'b1;
                            state  <= WB_IDLE;
                        end else begin
                            m_axi_awvalid <= 1'b1;
                            state         <= WB_ADDR;
                        end
                    end
                end
                default: state <= WB_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            m_axi_awaddr <= {wb_tag, {PAGE_OFS_W{1'b0}}};
        end else if (state == WB_ADDR && m_axi_awready) begin
            m_axi_awaddr <= m_axi_awaddr + BURST_BYTES;
        end
        if (load) begin
            m_axi_wdata <= brd_data;
        end
    end

endmodule

//--- hdl/page_refill.sv
module page_refill import page_cache_pkg::*; #(
    parameter int BURST_BEATS = AXI_BURST_BEATS
) (
    input  logic       CLK,
    input  logic       RST,
    input  logic       fill_req,
    input  page_tag_t  fill_tag,
    output logic       fill_ack,
    output addr_t      m_axi_araddr,
    output axi_len_t   m_axi_arlen,
    output axi_size_t  m_axi_arsize,
    output axi_burst_t m_axi_arburst,
    output logic       m_axi_arvalid,
    input  logic       m_axi_arready,
    input  word_t      m_axi_rdata,
    input  logic       m_axi_rlast,
    input  logic       m_axi_rvalid,
    output logic       m_axi_rready,
    output logic       bwr_en,
    output word_idx_t  bwr_idx,
    output word_t      bwr_data
);

    localparam addr_t BURST_BYTES = addr_t'(BURST_BEATS * 4);

    refill_state_t state;
    word_idx_t     widx;

    assign m_axi_arlen   = axi_len_t'(BURST_BEATS - 1);
    assign m_axi_arsize  = AXI_SIZE_WORD;
    assign m_axi_arburst = AXI_BURST_INCR;
    assign m_axi_rready  = (state == RF_DATA);

    assign bwr_en   = (state == RF_DATA) && m_axi_rvalid;
    assign bwr_idx  = widx;
    assign bwr_data = m_axi_rdata;

    always_ff @(posedge CLK) begin
        if (RST) begin
            state         <= RF_IDLE;
            m_axi_arvalid <= 1'b0;
            fill_ack      <= 1'b0;
            widx          <= '0;
        end else begin
            case (state)
                RF_IDLE: begin
                    if (fill_req && !fill_ack) begin
                        m_axi_arvalid <= 1'b1;
                        widx          <= '0;
                        state         <= RF_ADDR;
                    end else if (!fill_req) begin
                        fill_ack <= 1'b0;
                    end
                end
                RF_ADDR: begin
                    if (m_axi_arready) begin
                        m_axi_arvalid <= 1'b0;
                        state         <= RF_DATA;
                    end
                end
                RF_DATA: begin
                    if (m_axi_rvalid) begin
                        widx <= widx + 1'b1;
                        if (m_axi_rlast) begin
                            // address already points past this burst
                            if (m_axi_araddr[PAGE_OFS_W-1:0] == '0) begin
                                fill_ack <= 1'b1;
                                state    <= RF_IDLE;
                            end else begin
                                m_axi_arvalid <= 1'b1;
                                state         <= RF_ADDR;
                            end
                        end
                    end
                end
                default: state <= RF_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == RF_IDLE && fill_req && !fill_ack) begin
            m_axi_araddr <= {fill_tag, {PAGE_OFS_W{1'b0}}};
        end else if (state == RF_ADDR && m_axi_arready) begin
            m_axi_araddr <= m_axi_araddr + BURST_BYTES;
        end
    end

endmodule

//--- hdl/page_cache_ctrl.sv
module page_cache_ctrl import page_cache_pkg::*; (
    input  logic      CLK,
    input  logic      RST,
    input  logic      stall,
    input  cpu_req_t  req,
    output logic      hit,
    output logic      rvalid,
    output addr_t     roaddr,
    output logic      wb_req,
    output page_tag_t wb_tag,
    input  logic      wb_ack,
    output logic      fill_req,
    output page_tag_t fill_tag,
    input  logic      fill_ack
);

    ctrl_state_t state;
    page_tag_t   tag;
    logic        dirty;
    logic        miss;

    assign miss   = req.rden && (page_of(req.raddr) != tag);
    assign hit    = !miss;
    assign wb_tag = tag;

    always_ff @(posedge CLK) begin
        if (RST) begin
            state    <= CTRL_READY;
            wb_req   <= 1'b0;
            fill_req <= 1'b0;
            tag      <= INVALID_TAG;
            dirty    <= 1'b0;
        end else begin
            case (state)
                CTRL_READY: begin
                    if (miss && dirty) begin
                        wb_req <= 1'b1;
                        state  <= CTRL_WRITEBACK;
                    end else if (miss) begin
                        fill_req <= 1'b1;
                        state    <= CTRL_REFILL;
                    end
                end
                CTRL_WRITEBACK: begin
                    // drop req on ack, then wait for ack to fall
                    if (wb_req && wb_ack) begin
                        wb_req <= 1'b0;
                    end else if (!wb_req && !wb_ack) begin
                        fill_req <= 1'b1;
                        state    <= CTRL_REFILL;
                    end
                end
                CTRL_REFILL: begin
                    if (fill_req && fill_ack) begin
                        fill_req <= 1'b0;
                        tag      <= fill_tag;
                        dirty    <= 1'b0;
                    end else if (!fill_req && !fill_ack) begin
                        state <= CTRL_READY;
                    end
                end
                default: state <= CTRL_READY;
            endcase
            if (req.wren) begin
                dirty <= 1'b1;
            end
        end
    end

    // new page number, latched at the miss
    always_ff @(posedge CLK) begin
        if (state == CTRL_READY && miss) begin
            fill_tag <= page_of(req.raddr);
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            rvalid <= 1'b0;
        end else if (!stall) begin
            rvalid <= req.rden && !miss;
        end
    end

    always_ff @(posedge CLK) begin
        if (!stall) begin
            roaddr <= req.raddr;
        end
    end

endmodule

//--- hdl/page_store.sv
module page_store import page_cache_pkg::*; (
    input  logic      CLK,
    input  logic      RST,
    input  logic      stall,
    input  cpu_req_t  req,
    output word_t     rdata,
    input  logic      bwr_en,
    input  word_idx_t bwr_idx,
    input  word_t     bwr_data,
    input  word_idx_t brd_idx,
    output word_t     brd_data
);

    word_t mem [0:(1 << WORD_IDX_W)-1];

    word_idx_t ridx;
    word_idx_t widx;
    logic      fwd;

    assign ridx = word_of(req.raddr);
    assign widx = word_of(req.waddr);
    assign fwd  = req.wren && (ridx == widx);

    // processor write wins over a refill beat
    always_ff @(posedge CLK) begin
        if (req.wren) begin
            mem[widx] <= req.wdata;
        end else if (bwr_en) begin
            mem[bwr_idx] <= bwr_data;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            rdata <= '0;
        end else if (!stall) begin
            rdata <= fwd ? req.wdata : mem[ridx];
        end
    end

    // writeback side, one cycle behind the index
    always_ff @(posedge CLK) begin
        brd_data <= mem[brd_idx];
    end

endmodule

//--- hdl/page_cache_pkg.sv
package page_cache_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int PAGE_OFS_W = 12;
    localparam int WORD_IDX_W = 10;

    typedef logic [ADDR_W-1:0]            addr_t;
    typedef logic [WORD_W-1:0]            word_t;
    typedef logic [ADDR_W-PAGE_OFS_W-1:0] page_tag_t;
    typedef logic [WORD_IDX_W-1:0]        word_idx_t;

    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;

    localparam int         AXI_BURST_BEATS = 32;
    localparam axi_size_t  AXI_SIZE_WORD   = 3'b010;
    localparam axi_burst_t AXI_BURST_INCR  = 2'b01;
    localparam page_tag_t  INVALID_TAG     = '1;

    typedef struct packed {
        logic  rden;
        logic  wren;
        addr_t raddr;
        addr_t waddr;
        word_t wdata;
    } cpu_req_t;

    typedef enum logic [1:0] {RF_IDLE, RF_ADDR, RF_DATA} refill_state_t;
    typedef enum logic [1:0] {WB_IDLE, WB_ADDR, WB_DATA, WB_RESP} wb_state_t;
    typedef enum logic [1:0] {CTRL_READY, CTRL_WRITEBACK, CTRL_REFILL} ctrl_state_t;

    function automatic page_tag_t page_of(addr_t a);
        return a[ADDR_W-1:PAGE_OFS_W];
    endfunction

    function automatic word_idx_t word_of(addr_t a);
        return a[PAGE_OFS_W-1:2];
    endfunction

endpackage
